//--- common/replay_defines.svh
// Replay queue sizes and thresholds
// Shared by the type package and the queue blocks

`ifndef REPLAY_DEFINES_SVH
`define REPLAY_DEFINES_SVH

// Number of queue entries
`define RQ_ENTRY_NUM 8

// Largest interval stored in an entry
`define RQ_MAX_INTERVAL 6

// Pushes that can still arrive after stallUpper rises
`define RQ_STALL_MARGIN 2

// Miss-status registers in the load unit
`define MSHR_NUM 4

// Operation fields
`define ACTIVE_LIST_PTR_WIDTH 5
`define OP_PAYLOAD_WIDTH 16

`endif

//--- common/ReplayTypes.sv
// Replay queue types
// Vector typedefs and the packed structs passed between blocks

`include "replay_defines.svh"

package ReplayTypes;

    typedef logic [$clog2(`RQ_ENTRY_NUM)-1:0] RqIndex;
    typedef logic [$clog2(`RQ_ENTRY_NUM + 1)-1:0] RqCount;
    typedef logic [$clog2(`RQ_MAX_INTERVAL + 1)-1:0] RqInterval;
    typedef logic [`ACTIVE_LIST_PTR_WIDTH-1:0] ActiveListPtr;
    typedef logic [$clog2(`MSHR_NUM)-1:0] MshrId;
    typedef logic [`OP_PAYLOAD_WIDTH-1:0] OpPayload;

    // Integer issue slot
    typedef struct packed {
        logic valid;
        ActiveListPtr ptr;
        OpPayload payload;
    } IntSlot;

    // Memory issue slot, loads may hold a miss register
    typedef struct packed {
        logic valid;
        ActiveListPtr ptr;
        OpPayload payload;
        logic isLoad;
        logic hasMshr;
        MshrId mshrId;
    } MemSlot;

    // One recorded cycle of issue
    typedef struct packed {
        IntSlot intSlot;
        MemSlot memSlot;
        RqInterval interval;
    } RqEntry;

    // Recovery range, head and tail inclusive
    typedef struct packed {
        logic valid;
        ActiveListPtr head;
        ActiveListPtr tail;
        logic flushAll;
    } FlushRange;

    typedef struct packed {
        logic [`MSHR_NUM-1:0] valid;
        logic [`MSHR_NUM-1:0] ready;
    } MshrState;

endpackage

//--- replayQueue/ReplayRecorder.sv
// Replay recorder
// Packs the issued slots with the interval since the previous push
// and decides whether the cycle is written to the queue

`include "replay_defines.svh"

module ReplayRecorder
    import ReplayTypes::*;
(
    input  logic   clk,
    input  logic   rst,
    input  IntSlot recordInt,
    input  MemSlot recordMem,
    input  logic   queueHasValid,
    input  logic   full,
    output logic   pushEntry,
    output RqEntry pushData
);

    // Cycles since the last push, saturating
    RqInterval intervalIn;
    logic anyValid;

    always_comb begin
        anyValid = recordInt.valid | recordMem.valid;

        // Empty cycles are kept only while valid ops wait in the queue,
        // otherwise the spacing carries no information
        pushEntry = !full && (anyValid || queueHasValid);
    end

    always_comb begin
        pushData.intSlot = recordInt;
        pushData.memSlot = recordMem;
        pushData.interval = intervalIn;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            intervalIn <= '0;
        end
        else if (pushEntry) begin
            intervalIn <= '0;
        end
        else if (intervalIn != RqInterval'(`RQ_MAX_INTERVAL)) begin
            intervalIn <= intervalIn + 1'b1;
        end
    end

endmodule

//--- replayQueue/ReplayEntryStore.sv
// Replay entry store
// Circular buffer of recorded entries with occupancy tracking
// and the almost-full threshold for the upper-stage stall

`include "replay_defines.svh"

module ReplayEntryStore
    import ReplayTypes::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   pushEntry,
    input  RqEntry pushData,
    input  logic   popEntry,
    output RqEntry headEntry,
    output logic   empty,
    output logic   full,
    output logic   queueHasValid,
    output logic   almostFull,
    output RqCount count
);

    RqEntry entries [`RQ_ENTRY_NUM];
    RqIndex headPtr;
    RqIndex tailPtr;
    // Entries that hold at least one valid op
    RqCount validCount;
    logic pushValid;
    logic popValid;

    function automatic RqIndex nextIndex(RqIndex idx);
        return (idx == RqIndex'(`RQ_ENTRY_NUM - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign headEntry = entries[headPtr];
    assign empty = (count == '0);
    assign full = (count == RqCount'(`RQ_ENTRY_NUM));
    assign almostFull = (count >= RqCount'(`RQ_ENTRY_NUM - `RQ_STALL_MARGIN));
    assign queueHasValid = (validCount != '0);

    assign pushValid = pushEntry && (pushData.intSlot.valid || pushData.memSlot.valid);
    assign popValid = popEntry && (headEntry.intSlot.valid || headEntry.memSlot.valid);

    always_ff @(posedge clk) begin
        if (pushEntry) begin
            entries[tailPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            validCount <= '0;
        end
        else begin
            if (pushEntry) tailPtr <= nextIndex(tailPtr);
            if (popEntry) headPtr <= nextIndex(headPtr);
            count <= count + RqCount'(pushEntry) - RqCount'(popEntry);
            validCount <= validCount + RqCount'(pushValid) - RqCount'(popValid);
        end
    end

endmodule

//--- replayQueue/ReplayIssuer.sv
// Replay issuer
// Pops the head entry once its interval has elapsed and its load
// is not waiting on a miss register, drops flushed ops and
// registers the replayed slots

`include "replay_defines.svh"

module ReplayIssuer
    import ReplayTypes::*;
(
    input  logic      clk,
    input  logic      rst,
    input  RqEntry    headEntry,
    input  logic      empty,
    input  logic      almostFull,
    input  RqCount    count,
    input  FlushRange recovery,
    input  MshrState  mshr,
    output logic      popEntry,
    output IntSlot    replayInt,
    output MemSlot    replayMem,
    output logic      replay,
    output logic      stallUpper
);

    RqInterval intervalCount;

    // Registered recovery range and the number of replays it still covers
    FlushRange regRange;
    FlushRange windowRange;
    RqCount windowCount;

    logic headValid;
    logic flushInt;
    logic flushMem;
    logic mshrHold;

    function automatic logic rangeHit(FlushRange range, ActiveListPtr ptr);
        logic inRange;
        if (range.head <= range.tail) begin
            inRange = (ptr >= range.head) && (ptr <= range.tail);
        end
        else begin
            // Range wraps around the active list
            inRange = (ptr >= range.head) || (ptr <= range.tail);
        end
        return range.valid && (range.flushAll || inRange);
    endfunction

    always_comb begin
        windowRange = regRange;
        windowRange.valid = (windowCount != '0);

        flushInt = rangeHit(recovery, headEntry.intSlot.ptr)
            || rangeHit(windowRange, headEntry.intSlot.ptr);
        flushMem = rangeHit(recovery, headEntry.memSlot.ptr)
            || rangeHit(windowRange, headEntry.memSlot.ptr);

        // A flushed load never gets its data, so it must not hold the head
        mshrHold = headEntry.memSlot.valid && !flushMem
            && headEntry.memSlot.isLoad && headEntry.memSlot.hasMshr
            && mshr.valid[headEntry.memSlot.mshrId]
            && !mshr.ready[headEntry.memSlot.mshrId];

        headValid = headEntry.intSlot.valid || headEntry.memSlot.valid;
        popEntry = !empty && (intervalCount >= headEntry.interval)
            && (!headValid || !mshrHold);
    end

    assign stallUpper = replay | almostFull;

    always_ff @(posedge clk) begin
        if (rst) begin
            replayInt.valid <= 1'b0;
            replayMem.valid <= 1'b0;
            replay <= 1'b0;
            intervalCount <= '0;
        end
        else begin
            replayInt <= headEntry.intSlot;
            replayInt.valid <= popEntry && headEntry.intSlot.valid && !flushInt;
            replayMem <= headEntry.memSlot;
            replayMem.valid <= popEntry && headEntry.memSlot.valid && !flushMem;
            replay <= popEntry && headValid;

            if (popEntry) begin
                intervalCount <= '0;
            end
            else if (intervalCount != RqInterval'(`RQ_MAX_INTERVAL)) begin
                intervalCount <= intervalCount + 1'b1;
            end
        end
    end

    // Every entry present at recovery time sees the range
    always_ff @(posedge clk) begin
        if (rst) begin
            windowCount <= '0;
        end
        else if (recovery.valid) begin
            windowCount <= count;
            regRange <= recovery;
        end
        else if (windowCount != '0 && replay) begin
            windowCount <= windowCount - 1'b1;
        end
    end

endmodule

//--- design/ReplayQueueTop.sv
// Replay queue top level
// Recorder feeds the entry store, the issuer drains it

module ReplayQueueTop
    import ReplayTypes::*;
(
    input  logic      clk,
    input  logic      rst,
    input  IntSlot    recordInt,
    input  MemSlot    recordMem,
    input  FlushRange recovery,
    input  MshrState  mshr,
    output IntSlot    replayInt,
    output MemSlot    replayMem,
    output logic      replay,
    output logic      stallUpper
);

    logic pushEntry;
    RqEntry pushData;
    logic popEntry;
    RqEntry headEntry;
    logic empty;
    logic full;
    logic queueHasValid;
    logic almostFull;
    RqCount count;

    ReplayRecorder ReplayRecorder_inst (
        .clk(clk),
        .rst(rst),
        .recordInt(recordInt),
        .recordMem(recordMem),
        .queueHasValid(queueHasValid),
        .full(full),
        .pushEntry(pushEntry),
        .pushData(pushData)
    );

    ReplayEntryStore ReplayEntryStore_inst (
        .clk(clk),
        .rst(rst),
        .pushEntry(pushEntry),
        .pushData(pushData),
        .popEntry(popEntry),
        .headEntry(headEntry),
        .empty(empty),
        .full(full),
        .queueHasValid(queueHasValid),
        .almostFull(almostFull),
        .count(count)
    );

    ReplayIssuer ReplayIssuer_inst (
        .clk(clk),
        .rst(rst),
        .headEntry(headEntry),
        .empty(empty),
        .almostFull(almostFull),
        .count(count),
        .recovery(recovery),
        .mshr(mshr),
        .popEntry(popEntry),
        .replayInt(replayInt),
        .replayMem(replayMem),
        .replay(replay),
        .stallUpper(stallUpper)
    );

endmodule

//--- dv/ReplayQueue_chk.sv
// Replay queue port checker
// Concurrent assertions on the top-level replay and stall outputs

module ReplayQueue_chk
    import ReplayTypes::*;
(
    input logic   clk,
    input logic   rst,
    input IntSlot replayInt,
    input MemSlot replayMem,
    input logic   replay,
    input logic   stallUpper
);

    timeunit 1ns;
    timeprecision 1ps;

    // A visible slot always comes with the replay flag
    validImpliesReplay: assert property (
        @(posedge clk) disable iff (rst)
        (replayInt.valid || replayMem.valid) |-> replay
    ) else $error("replay output slot valid without replay");

    // Upper stages are held while the queue replays
    replayImpliesStall: assert property (
        @(posedge clk) disable iff (rst)
        replay |-> stallUpper
    ) else $error("replay without stallUpper");

    resetQuiet: assert property (
        @(posedge clk) rst |-> !replay
    ) else $error("replay high during reset");

endmodule

//--- dv/ReplayQueueTb.sv
// Replay queue testbench
// Random record stream with recoveries and miss-register holds,
// checked against a queue model of the recorded operations

`include "replay_defines.svh"

module ReplayQueueTb
    import ReplayTypes::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Roughly 1100 cycles of stimulus and drain, with ample margin
    localparam int CycleLimit = 4000;
    localparam int RecordCycles = 800;

    typedef struct {
        bit isMem;
        ActiveListPtr ptr;
        OpPayload payload;
        bit isLoad;
        bit hasMshr;
        MshrId mshrId;
        int recCycle;
    } ModelOp;

    logic clk;
    logic rst;
    IntSlot recordInt;
    MemSlot recordMem;
    FlushRange recovery;
    MshrState mshr;
    IntSlot replayInt;
    MemSlot replayMem;
    logic replay;
    logic stallUpper;

    ModelOp modelQ[$];
    MshrState mshrPrev;
    int mshrPhase[`MSHR_NUM];
    int mshrTimer[`MSHR_NUM];
    logic [31:0] lcgState = 32'd62;
    ActiveListPtr nextPtr = '0;
    int stimCycle = 0;
    int negCycle = 0;
    int cycleCount = 0;
    int postReset = 0;
    int validEntries = 0;
    int replaysSinceRecovery = `RQ_ENTRY_NUM + 1;
    bit stallSeen = 0;
    bit thisCycleValid = 0;
    bit lastCycleValid = 0;
    bit haveLast = 0;
    int lastReplayCycle = 0;
    int lastRecCycle = 0;

    ReplayQueueTop ReplayQueueTop_inst (
        .clk(clk),
        .rst(rst),
        .recordInt(recordInt),
        .recordMem(recordMem),
        .recovery(recovery),
        .mshr(mshr),
        .replayInt(replayInt),
        .replayMem(replayMem),
        .replay(replay),
        .stallUpper(stallUpper)
    );

    bind ReplayQueueTop ReplayQueue_chk ReplayQueue_chk_inst (
        .clk(clk),
        .rst(rst),
        .replayInt(replayInt),
        .replayMem(replayMem),
        .replay(replay),
        .stallUpper(stallUpper)
    );

    function logic [15:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    // Inclusive range with wraparound, or everything on flushAll
    function automatic bit inFlushRange(FlushRange r, ActiveListPtr p);
        if (r.flushAll) return 1'b1;
        if (r.head <= r.tail) return (p >= r.head) && (p <= r.tail);
        return (p >= r.head) || (p <= r.tail);
    endfunction

    task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "check %s mismatched", name);
        end
    endtask

    task automatic matchReplay(bit isMem, ActiveListPtr ptr, OpPayload payload,
                               output ModelOp op);
        check("replay with model op pending", 1, modelQ.size() > 0);
        op = modelQ.pop_front();
        check("replay slot kind", op.isMem, isMem);
        check("replay pointer", op.ptr, ptr);
        check("replay payload", op.payload, payload);
    endtask

    // Waiting, then ready for a while, then idle again
    task automatic updateMshr(output MshrState next);
        for (int i = 0; i < `MSHR_NUM; i++) begin
            case (mshrPhase[i])
                0: if (nextRandom() % 8 == 0) begin
                    mshrPhase[i] = 1;
                    mshrTimer[i] = 1 + nextRandom() % 12;
                end
                1: if (mshrTimer[i] == 0) begin
                    mshrPhase[i] = 2;
                    mshrTimer[i] = 1 + nextRandom() % 4;
                end else mshrTimer[i]--;
                default: if (mshrTimer[i] == 0) mshrPhase[i] = 0;
                    else mshrTimer[i]--;
            endcase
            next.valid[i] = (mshrPhase[i] != 0);
            next.ready[i] = (mshrPhase[i] == 2);
        end
    endtask

    // mode 0 no recovery, 1 occasional range recovery, 2 flush-all
    task automatic stepCycle(bit allowRecord, int mode);
        MshrState nextMshr;
        FlushRange rec;
        IntSlot iSlot;
        MemSlot mSlot;
        @(posedge clk);
        stimCycle++;
        mshrPrev = mshr;
        updateMshr(nextMshr);
        mshr <= nextMshr;
        rec = '0;
        // A new range waits until every entry seen by the previous one has left
        if (mode == 1 && replaysSinceRecovery > `RQ_ENTRY_NUM
            && nextRandom() % 40 == 0) begin
            rec.valid = 1'b1;
            rec.tail = nextPtr - 1'b1;
            rec.head = rec.tail - ActiveListPtr'(nextRandom() % 4);
        end
        else if (mode == 2) begin
            rec.valid = 1'b1;
            rec.flushAll = 1'b1;
        end
        recovery <= rec;
        iSlot = '0;
        mSlot = '0;
        if (allowRecord && !stallSeen && nextRandom() % 4 != 0) begin
            iSlot.valid = (nextRandom() % 2 == 1);
            mSlot.valid = !iSlot.valid || (nextRandom() % 2 == 1);
        end
        if (iSlot.valid) begin
            iSlot.ptr = nextPtr++;
            iSlot.payload = nextRandom();
            modelQ.push_back('{0, iSlot.ptr, iSlot.payload, 0, 0, '0, stimCycle});
        end
        if (mSlot.valid) begin
            mSlot.ptr = nextPtr++;
            mSlot.payload = nextRandom();
            mSlot.isLoad = (nextRandom() % 2 == 1);
            mSlot.hasMshr = mSlot.isLoad && (nextRandom() % 2 == 1);
            mSlot.mshrId = MshrId'(nextRandom());
            modelQ.push_back('{1, mSlot.ptr, mSlot.payload, mSlot.isLoad,
                               mSlot.hasMshr, mSlot.mshrId, stimCycle});
        end
        recordInt <= iSlot;
        recordMem <= mSlot;
        lastCycleValid = thisCycleValid;
        thisCycleValid = iSlot.valid || mSlot.valid;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Something failed");
            $fatal(1, "Run timed out after %0d cycles", cycleCount);
        end
    end

    // Outputs are sampled at the falling edge, away from the drive edge
    always @(negedge clk) begin
        ModelOp kept[$];
        ModelOp op;
        int recCycle;
        int gap;
        int minGap;
        bit anyOut;
        negCycle++;
        if (rst || postReset < 3) begin
            check("reset replay", 0, replay);
            check("reset stallUpper", 0, stallUpper);
            check("reset int valid", 0, replayInt.valid);
            check("reset mem valid", 0, replayMem.valid);
        end
        stallSeen = stallUpper;
        if (!rst) begin
            postReset++;
            validEntries += int'(lastCycleValid);
            if (replay) validEntries--;
            if (replay) replaysSinceRecovery++;
            if (replay) check("stall during replay", 1, stallUpper);
            if (validEntries >= `RQ_ENTRY_NUM - `RQ_STALL_MARGIN)
                check("stall at occupancy", 1, stallUpper);
            anyOut = 1'b0;
            recCycle = 0;
            if (replayInt.valid) begin
                matchReplay(0, replayInt.ptr, replayInt.payload, op);
                recCycle = op.recCycle;
                anyOut = 1'b1;
            end
            if (replayMem.valid) begin
                matchReplay(1, replayMem.ptr, replayMem.payload, op);
                check("replay isLoad", op.isLoad, replayMem.isLoad);
                check("replay hasMshr", op.hasMshr, replayMem.hasMshr);
                check("replay mshrId", op.mshrId, replayMem.mshrId);
                recCycle = op.recCycle;
                anyOut = 1'b1;
                if (op.isLoad && op.hasMshr && mshrPrev.valid[op.mshrId])
                    check("mshr ready before load replay", 1,
                          mshrPrev.ready[op.mshrId]);
            end
            if (anyOut) begin
                if (haveLast) begin
                    gap = negCycle - lastReplayCycle;
                    minGap = recCycle - lastRecCycle;
                    if (minGap > `RQ_MAX_INTERVAL) minGap = `RQ_MAX_INTERVAL;
                    if (gap < minGap) check("replay spacing", minGap, gap);
                end
                haveLast = 1'b1;
                lastReplayCycle = negCycle;
                lastRecCycle = recCycle;
            end
            // Ops in the range must not show up after this cycle
            if (recovery.valid) begin
                replaysSinceRecovery = 0;
                kept.delete();
                foreach (modelQ[i])
                    if (!inFlushRange(recovery, modelQ[i].ptr)) kept.push_back(modelQ[i]);
                modelQ = kept;
            end
        end
    end

    initial begin
        rst = 1'b1;
        recordInt = '0;
        recordMem = '0;
        recovery = '0;
        mshr = '0;
        mshrPrev = '0;
        for (int i = 0; i < `MSHR_NUM; i++) begin
            mshrPhase[i] = 0;
            mshrTimer[i] = 0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) stepCycle(0, 0);
        for (int n = 0; n < RecordCycles; n++) stepCycle(1, 1);
        while (modelQ.size() != 0) stepCycle(0, 0);
        repeat (5) stepCycle(1, 0);
        stepCycle(0, 2);
        // Any op that leaks past the flush-all shows up within this
        repeat (80) stepCycle(0, 0);
        $display("Everything OK");
        $finish;
    end

endmodule

//--- project.f
+incdir+common
common/ReplayTypes.sv
replayQueue/ReplayRecorder.sv
replayQueue/ReplayEntryStore.sv
replayQueue/ReplayIssuer.sv
design/ReplayQueueTop.sv
dv/ReplayQueue_chk.sv
dv/ReplayQueueTb.sv

//--- Makefile
# Verilator build for the replay queue testbench

VERILATOR ?= verilator
TOP ?= ReplayQueueTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= project.f
VFLAGS ?= --binary --timing --assert -Wall
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
